// ==== hw/cc_pkg.sv ====
`default_nettype none

package cc_pkg;

    // ======================================================================
    // request queue
    // ======================================================================

    // opaque work request word
    localparam int REQ_BITS  = 64;
    localparam int QDEPTH    = 8;
    localparam int QPTR_BITS = $clog2(QDEPTH);

    // ======================================================================
    // dcqcn reaction point, scaled down for short runs
    // ======================================================================

    localparam int GAP_BITS   = 16;
    localparam int TIMER_BITS = 24;

    // gap values are in cycles between releases
    localparam logic [GAP_BITS-1:0] RC_INIT  = 16'd32;
    localparam logic [GAP_BITS-1:0] RT_INIT  = 16'd32;
    localparam logic [GAP_BITS-1:0] RC_MIN   = 16'd4;
    localparam logic [GAP_BITS-1:0] RC_MAX   = 16'd1024;
    localparam logic [GAP_BITS-1:0] RAI_STEP = 16'd16;

    // spacing between two reductions
    localparam logic [TIMER_BITS-1:0] MIN_MARK_INTERVAL = 24'd40;
    // mark-free stretch before alpha relaxes
    localparam logic [TIMER_BITS-1:0] ALPHA_RELAX_TIME  = 24'd60;

    // increase event sources
    localparam int TIME_THRESHOLD = 100;
    localparam int BYTE_THRESHOLD = 7;
    localparam int F_STAGES       = 5;

    // multipliers in 1/128 units, index 0 doubles the gap
    localparam int ALPHA_MAX_INDEX = 7;
    localparam logic [8:0] ALPHA_TABLE [0:ALPHA_MAX_INDEX] = '{
        9'd256, 9'd228, 9'd209, 9'd194, 9'd182, 9'd166, 9'd156, 9'd144
    };

endpackage

`default_nettype wire

// ==== hw/meta_fifo.sv ====
`default_nettype none

module meta_fifo (
    input  logic                        aclk,
    input  logic                        aresetn,

    // write side
    input  logic                        s_valid,
    output logic                        s_ready,
    input  logic [cc_pkg::REQ_BITS-1:0] s_data,

    // read side, head of queue
    output logic                        m_valid,
    input  logic                        m_ready,
    output logic [cc_pkg::REQ_BITS-1:0] m_data
);

    logic [cc_pkg::REQ_BITS-1:0]  mem_q [0:cc_pkg::QDEPTH-1];
    logic [cc_pkg::QPTR_BITS-1:0] wr_ptr_q;
    logic [cc_pkg::QPTR_BITS-1:0] rd_ptr_q;
    logic [cc_pkg::QPTR_BITS:0]   count_q;
    logic                         push;
    logic                         pop;

    // full only at QDEPTH words
    assign s_ready = (count_q != cc_pkg::QDEPTH);
    assign m_valid = (count_q != '0);
    assign m_data  = mem_q[rd_ptr_q];

    assign push = s_valid && s_ready;
    assign pop  = m_valid && m_ready;

    // storage
    always_ff @(posedge aclk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= s_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop keeps occupancy
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/dcqcn_rate_ctrl.sv ====
`default_nettype none

module dcqcn_rate_ctrl (
    input  logic                        aclk,
    input  logic                        aresetn,

    // ack feedback, one pulse per ack
    input  logic                        ack_valid,
    input  logic                        ack_ecn,

    // current inter-request gap
    output logic [cc_pkg::GAP_BITS-1:0] gap
);

    // free timer and event timestamps
    logic [cc_pkg::TIMER_BITS-1:0] timer_q;
    logic [cc_pkg::TIMER_BITS-1:0] last_update_q;
    logic [cc_pkg::TIMER_BITS-1:0] last_update_d;
    logic [cc_pkg::TIMER_BITS-1:0] last_mark_q;
    logic [cc_pkg::TIMER_BITS-1:0] last_mark_d;
    logic [cc_pkg::TIMER_BITS-1:0] since_update;
    logic [cc_pkg::TIMER_BITS-1:0] since_mark;

    // increase counters
    logic [$clog2(cc_pkg::TIME_THRESHOLD)-1:0]  time_cnt_q;
    logic [$clog2(cc_pkg::TIME_THRESHOLD)-1:0]  time_cnt_d;
    logic [$clog2(cc_pkg::BYTE_THRESHOLD)-1:0]  ack_cnt_q;
    logic [$clog2(cc_pkg::BYTE_THRESHOLD)-1:0]  ack_cnt_d;
    logic [$clog2(cc_pkg::F_STAGES+1)-1:0]      t_stage_q;
    logic [$clog2(cc_pkg::F_STAGES+1)-1:0]      t_stage_d;
    logic [$clog2(cc_pkg::F_STAGES+1)-1:0]      b_stage_q;
    logic [$clog2(cc_pkg::F_STAGES+1)-1:0]      b_stage_d;
    logic                                       inc_event_q;
    logic                                       inc_event_d;

    // rate state
    logic [$clog2(cc_pkg::ALPHA_MAX_INDEX+1)-1:0] alpha_q;
    logic [$clog2(cc_pkg::ALPHA_MAX_INDEX+1)-1:0] alpha_d;
    logic [cc_pkg::GAP_BITS-1:0]                  gap_q;
    logic [cc_pkg::GAP_BITS-1:0]                  gap_d;
    logic [cc_pkg::GAP_BITS-1:0]                  target_q;
    logic [cc_pkg::GAP_BITS-1:0]                  target_d;

    // datapath helpers
    logic [cc_pkg::GAP_BITS+8:0] scaled_gap;
    logic [cc_pkg::GAP_BITS:0]   avg_sum;
    logic [cc_pkg::GAP_BITS-1:0] target_dec;
    logic                        time_hit;
    logic                        ack_hit;
    logic                        reduce;
    logic                        relax;

    assign gap = gap_q;

    // modulo differences, timer wrap is harmless
    assign since_update = timer_q - last_update_q;
    assign since_mark   = timer_q - last_mark_q;

    assign time_hit = (time_cnt_q == cc_pkg::TIME_THRESHOLD - 1);
    assign ack_hit  = ack_valid && (ack_cnt_q == cc_pkg::BYTE_THRESHOLD - 1);
    assign reduce   = ack_valid && ack_ecn && (since_update > cc_pkg::MIN_MARK_INTERVAL);
    assign relax    = (since_mark > cc_pkg::ALPHA_RELAX_TIME);

    // gap times multiplier, result in 1/128 units
    assign scaled_gap = gap_q * cc_pkg::ALPHA_TABLE[alpha_q];
    assign avg_sum    = gap_q + target_q;
    // additive step with floor
    assign target_dec = (target_q < cc_pkg::RC_MIN + cc_pkg::RAI_STEP) ?
                        cc_pkg::RC_MIN : target_q - cc_pkg::RAI_STEP;

    // ======================================================================
    // next state, later branches take priority
    // ======================================================================
    always_comb begin
        gap_d         = gap_q;
        target_d      = target_q;
        alpha_d       = alpha_q;
        last_update_d = last_update_q;
        last_mark_d   = last_mark_q;
        time_cnt_d    = time_cnt_q + 1'b1;
        ack_cnt_d     = ack_cnt_q;
        t_stage_d     = t_stage_q;
        b_stage_d     = b_stage_q;
        inc_event_d   = 1'b0;

        if (ack_valid) begin
            ack_cnt_d = ack_cnt_q + 1'b1;
        end
        // time driven increase
        if (time_hit) begin
            time_cnt_d  = '0;
            inc_event_d = 1'b1;
            if (t_stage_q < cc_pkg::F_STAGES) begin
                t_stage_d = t_stage_q + 1'b1;
            end
        end
        // ack count driven increase
        if (ack_hit) begin
            ack_cnt_d   = '0;
            inc_event_d = 1'b1;
            if (b_stage_q < cc_pkg::F_STAGES) begin
                b_stage_d = b_stage_q + 1'b1;
            end
        end

        // event registered last cycle acts now
        if (inc_event_q) begin
            // hyper increase folds into additive increase
            if (t_stage_q >= cc_pkg::F_STAGES || b_stage_q >= cc_pkg::F_STAGES) begin
                target_d = target_dec;
            end
            // fast recovery only averages
            gap_d = avg_sum[cc_pkg::GAP_BITS:1];
        end

        // long quiet period, weaker reduction
        if (relax) begin
            if (alpha_q != cc_pkg::ALPHA_MAX_INDEX) begin
                alpha_d = alpha_q + 1'b1;
            end
            last_mark_d = timer_q;
        end

        if (ack_valid && ack_ecn) begin
            last_mark_d = timer_q;
            // reduction wins over any pending increase
            if (reduce) begin
                target_d = gap_q;
                if (gap_q <= cc_pkg::RC_MAX) begin
                    gap_d = scaled_gap[cc_pkg::GAP_BITS+6:7];
                end
                if (alpha_q != '0) begin
                    alpha_d = alpha_q - 1'b1;
                end
                last_update_d = timer_q;
                time_cnt_d    = '0;
                ack_cnt_d     = '0;
                t_stage_d     = '0;
                b_stage_d     = '0;
                inc_event_d   = 1'b0;
            end
        end

        // floors on the value about to be stored
        if (gap_d < cc_pkg::RC_MIN) begin
            gap_d = cc_pkg::RC_MIN;
        end
        if (target_d < cc_pkg::RC_MIN) begin
            target_d = cc_pkg::RC_MIN;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            timer_q       <= '0;
            last_update_q <= '0;
            last_mark_q   <= '0;
            time_cnt_q    <= '0;
            ack_cnt_q     <= '0;
            t_stage_q     <= '0;
            b_stage_q     <= '0;
            inc_event_q   <= 1'b0;
            alpha_q       <= '0;
            gap_q         <= cc_pkg::RC_INIT;
            target_q      <= cc_pkg::RT_INIT;
        end else begin
            timer_q       <= timer_q + 1'b1;
            last_update_q <= last_update_d;
            last_mark_q   <= last_mark_d;
            time_cnt_q    <= time_cnt_d;
            ack_cnt_q     <= ack_cnt_d;
            t_stage_q     <= t_stage_d;
            b_stage_q     <= b_stage_d;
            inc_event_q   <= inc_event_d;
            alpha_q       <= alpha_d;
            gap_q         <= gap_d;
            target_q      <= target_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/send_pacer.sv ====
`default_nettype none

module send_pacer (
    input  logic                        aclk,
    input  logic                        aresetn,

    // allowed gap from the rate controller
    input  logic [cc_pkg::GAP_BITS-1:0] gap,

    // fifo head
    input  logic                        head_valid,
    output logic                        head_ready,
    input  logic [cc_pkg::REQ_BITS-1:0] head_data,

    // toward the network
    output logic                        m_valid,
    input  logic                        m_ready,
    output logic [cc_pkg::REQ_BITS-1:0] m_data
);

    logic [cc_pkg::TIMER_BITS-1:0] elapsed_q;
    logic                          open;

    // release window, gap+2 cycles between handshakes
    assign open = elapsed_q > {{(cc_pkg::TIMER_BITS-cc_pkg::GAP_BITS){1'b0}}, gap};

    assign m_valid    = head_valid && open;
    assign head_ready = m_ready && open;
    assign m_data     = head_data;

    // counts every cycle, sticks at all ones
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            elapsed_q <= '0;
        end else if (m_valid && m_ready) begin
            elapsed_q <= '0;
        end else if (elapsed_q != '1) begin
            elapsed_q <= elapsed_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cc_queue.sv ====
`default_nettype none

module cc_queue (
    input  logic                        aclk,
    input  logic                        aresetn,

    // congestion feedback
    input  logic                        ack_valid,
    input  logic                        ack_ecn,

    // work requests in
    input  logic                        s_valid,
    output logic                        s_ready,
    input  logic [cc_pkg::REQ_BITS-1:0] s_data,

    // paced requests out
    output logic                        m_valid,
    input  logic                        m_ready,
    output logic [cc_pkg::REQ_BITS-1:0] m_data
);

    // fifo head to pacer
    logic                        head_valid;
    logic                        head_ready;
    logic [cc_pkg::REQ_BITS-1:0] head_data;
    // current gap
    logic [cc_pkg::GAP_BITS-1:0] gap;

    meta_fifo fifo_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_data  (s_data),
        .m_valid (head_valid),
        .m_ready (head_ready),
        .m_data  (head_data)
    );

    send_pacer pacer_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .gap        (gap),
        .head_valid (head_valid),
        .head_ready (head_ready),
        .head_data  (head_data),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .m_data     (m_data)
    );

    dcqcn_rate_ctrl rate_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .ack_valid (ack_valid),
        .ack_ecn   (ack_ecn),
        .gap       (gap)
    );

endmodule

`default_nettype wire

// ==== tests/cc_queue_properties.sv ====
`default_nettype none

module cc_queue_properties (
    input wire logic                        aclk,
    input wire logic                        aresetn,
    input wire logic                        s_ready,
    input wire logic                        m_valid,
    input wire logic                        m_ready,
    input wire logic [cc_pkg::REQ_BITS-1:0] m_data
);

    // stalled output keeps its word
    assert property (@(posedge aclk) disable iff (!aresetn)
        m_valid && !m_ready |=> $stable(m_data))
        else $error("m_data changed while the output was stalled");

    // valid held until taken
    assert property (@(posedge aclk) disable iff (!aresetn)
        m_valid && !m_ready |=> m_valid)
        else $error("m_valid dropped before its handshake");

    // empty fifo right after reset
    assert property (@(posedge aclk) $rose(aresetn) |-> s_ready)
        else $error("s_ready low in the first cycle after reset");

endmodule

bind cc_queue cc_queue_properties props_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
);

`default_nettype wire

// ==== tests/tb_cc_queue.sv ====
`default_nettype none

module tb_cc_queue;

    localparam int MAX_TESTS = 16;

    logic                        aclk;
    logic                        aresetn;
    logic                        ack_valid;
    logic                        ack_ecn;
    logic                        s_valid;
    logic                        s_ready;
    logic [cc_pkg::REQ_BITS-1:0] s_data;
    logic                        m_valid;
    logic                        m_ready;
    logic [cc_pkg::REQ_BITS-1:0] m_data;

    // test table from the stimulus file
    string t_name  [MAX_TESTS];
    int    t_nreq  [MAX_TESTS];
    int    t_nack  [MAX_TESTS];
    int    t_ecn   [MAX_TESTS];
    int    t_stall [MAX_TESTS];
    int    t_gap   [MAX_TESTS];

    int num_tests;
    int total_reqs;
    int cycle_limit;
    int cycle_cnt;
    int pass_cnt;
    int fail_cnt;

    logic [15:0]                 lfsr_q;
    logic [cc_pkg::REQ_BITS-1:0] sent_q [$];

    cc_queue dut_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .ack_valid (ack_valid),
        .ack_ecn   (ack_ecn),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .s_data    (s_data),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .m_data    (m_data)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // ======================================================================
    // helpers
    // ======================================================================

    // 16 bit galois lfsr, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[62:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic read_stim();
        int    fd;
        int    n;
        int    a, b, c, d, e;
        string txt;
        string nm;
        fd = $fopen("tests/cc_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tests/cc_stim.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                txt = "";
                void'($fgets(txt, fd));
                // skip comments and blank lines
                if (txt.len() > 1 && txt.getc(0) != "#") begin
                    n = $sscanf(txt, "%s %d %d %d %d %d", nm, a, b, c, d, e);
                    if (n == 6) begin
                        t_name[num_tests]  = nm;
                        t_nreq[num_tests]  = a;
                        t_nack[num_tests]  = b;
                        t_ecn[num_tests]   = c;
                        t_stall[num_tests] = d;
                        t_gap[num_tests]   = e;
                        total_reqs += a;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // low for three rising edges, released on a falling edge
    task automatic reset_dut();
        @(negedge aclk);
        aresetn   = 1'b0;
        s_valid   = 1'b0;
        s_data    = '0;
        m_ready   = 1'b0;
        ack_valid = 1'b0;
        ack_ecn   = 1'b0;
        repeat (3) @(negedge aclk);
        aresetn = 1'b1;
    endtask

    // ======================================================================
    // one test: drive, score, measure gaps
    // ======================================================================
    task automatic run_test(input int idx);
        string       tname;
        int          nreq, nack, ecn, stall, exp_gap;
        int          accepted, delivered, acks_sent, tc, errs;
        int          last_hs, last_ack_tc, spacing, min_gap, ack_start;
        logic        exp_ready, full_seen, cong_checked;
        logic [63:0] cur_word;
        logic [63:0] bits;
        logic [63:0] expw;
        tname        = t_name[idx];
        nreq         = t_nreq[idx];
        nack         = t_nack[idx];
        ecn          = t_ecn[idx];
        stall        = t_stall[idx];
        exp_gap      = t_gap[idx];
        accepted     = 0;
        delivered    = 0;
        acks_sent    = 0;
        tc           = 0;
        errs         = 0;
        last_hs      = -1;
        last_ack_tc  = -1;
        min_gap      = 0;
        full_seen    = 1'b0;
        cong_checked = 1'b0;
        // marks land past the minimum reduction interval
        ack_start    = int'(cc_pkg::MIN_MARK_INTERVAL) + 10;
        sent_q.delete();
        draw_bits(cc_pkg::REQ_BITS, cur_word);
        reset_dut();

        while (delivered < nreq || acks_sent < nack) begin
            @(negedge aclk);
            tc++;
            // source always offers the next word
            s_valid = (accepted < nreq);
            s_data  = cur_word;
            if (stall == 0) begin
                m_ready = 1'b1;
            end else if (stall == 1) begin
                draw_bits(1, bits);
                m_ready = bits[0];
            end else begin
                draw_bits(2, bits);
                m_ready = &bits[1:0];
            end
            ack_valid = 1'b0;
            ack_ecn   = 1'b0;
            if (acks_sent < nack && tc >= ack_start && (tc - ack_start) % 4 == 0) begin
                ack_valid   = 1'b1;
                ack_ecn     = (ecn != 0);
                last_ack_tc = tc;
                acks_sent++;
            end
            // settle, then sample what the next edge sees
            #1;
            exp_ready = ((accepted - delivered) != cc_pkg::QDEPTH);
            if (s_ready !== exp_ready) begin
                $display("ERROR %s s_ready: expected %0b actual %0b", tname, exp_ready, s_ready);
                errs++;
            end
            if (!s_ready) begin
                full_seen = 1'b1;
            end
            if (s_valid && s_ready) begin
                sent_q.push_back(cur_word);
                accepted++;
                draw_bits(cc_pkg::REQ_BITS, cur_word);
            end
            if (m_valid && m_ready) begin
                if (sent_q.size() == 0) begin
                    $display("%s: output handshake with no request outstanding", tname);
                    errs++;
                end else begin
                    expw = sent_q.pop_front();
                    if (m_data !== expw) begin
                        $display("ERROR %s data: expected %h actual %h", tname, expw, m_data);
                        errs++;
                    end
                end
                delivered++;
                if (last_hs >= 0) begin
                    spacing = tc - last_hs;
                    if (min_gap == 0 || spacing < min_gap) begin
                        min_gap = spacing;
                    end
                    // floor of the gap register plus handshake overhead
                    if (spacing < int'(cc_pkg::RC_MIN) + 2) begin
                        $display("ERROR %s min gap: expected at least %0d actual %0d",
                                 tname, int'(cc_pkg::RC_MIN) + 2, spacing);
                        errs++;
                    end
                    if (ecn == 0 && exp_gap != 0 && stall == 0 && spacing != exp_gap) begin
                        $display("ERROR %s gap: expected %0d actual %0d",
                                 tname, exp_gap, spacing);
                        errs++;
                    end
                    // first whole interval after the last mark
                    if (ecn != 0 && !cong_checked && acks_sent == nack &&
                        last_ack_tc >= 0 && last_hs > last_ack_tc) begin
                        cong_checked = 1'b1;
                        if (spacing <= exp_gap) begin
                            $display("ERROR %s gap after marks: expected above %0d actual %0d",
                                     tname, exp_gap, spacing);
                            errs++;
                        end
                    end
                end
                last_hs = tc;
            end
        end

        if (accepted != nreq || delivered != nreq) begin
            $display("ERROR %s count: expected %0d actual %0d accepted %0d delivered",
                     tname, nreq, accepted, delivered);
            errs++;
        end
        if (stall != 0 && nreq > cc_pkg::QDEPTH && !full_seen) begin
            $display("%s: s_ready never dropped although the queue had to fill", tname);
            errs++;
        end
        if (ecn != 0 && exp_gap != 0 && !cong_checked) begin
            $display("%s: no handshake gap was measured after the marked acks", tname);
            errs++;
        end
        if (errs == 0) begin
            pass_cnt++;
            $display("test %s: ok, %0d words, min gap %0d", tname, delivered, min_gap);
        end else begin
            fail_cnt++;
            $display("test %s: FAILED with %0d errors", tname, errs);
        end
    endtask

    // ======================================================================
    // watchdog and main sequence
    // ======================================================================
    initial begin
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge aclk);
            cycle_cnt++;
        end
        $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
        $display("tests failed");
        $finish;
    end

    initial begin
        aresetn     = 1'b0;
        ack_valid   = 1'b0;
        ack_ecn     = 1'b0;
        s_valid     = 1'b0;
        s_data      = '0;
        m_ready     = 1'b0;
        lfsr_q      = 16'd63842;
        num_tests   = 0;
        total_reqs  = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        read_stim();
        // worst case one widest gap per request, plus resets
        cycle_limit = total_reqs * (int'(cc_pkg::RC_MAX) + 2) + num_tests * 200 + 1000;
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        if (num_tests == 0 && fail_cnt == 0) begin
            $display("no tests found in the stimulus file");
            fail_cnt++;
        end
        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/cc_stim.txt ====
# columns: name requests acks marked stall expected_gap
# stall 0 ready sink, 1 random stalls, 2 heavy stalls; gap exact if unmarked, floor if marked
pacing 8 0 0 0 34
order 20 0 0 0 0
acks 24 21 0 0 0
congestion 6 3 1 0 34
stall 24 0 0 1 0
heavy 30 10 0 2 0
single 1 0 0 0 0
burst 40 14 0 1 0

// ==== sources.f ====
hw/cc_pkg.sv
hw/meta_fifo.sv
hw/dcqcn_rate_ctrl.sv
hw/send_pacer.sv
hw/cc_queue.sv
tests/cc_queue_properties.sv
tests/tb_cc_queue.sv

// ==== Bender.yml ====
package:
  name: cc_queue

sources:
  # package first, then leaf modules, then the top level
  - hw/cc_pkg.sv
  - hw/meta_fifo.sv
  - hw/dcqcn_rate_ctrl.sv
  - hw/send_pacer.sv
  - hw/cc_queue.sv

  # testbench with bound assertions
  - target: test
    files:
      - tests/cc_queue_properties.sv
      - tests/tb_cc_queue.sv
